/* sim.f */
source/fw_chain_pkg.sv
source/fw_chain_top.sv
source/cmd_decoder.sv
source/config_regs.sv
source/config_clk_gen.sv
source/chain_shifter.sv
source/chain_test_fsm.sv
source/status_reg.sv
dv/tb_fw_chain.sv

/* dv/tb_fw_chain.sv */
// Directed testbench for the chain test block, stops at the first mismatch
// Inputs change 2 ns after the rising edge, outputs are sampled at that point too
// A full chain test at period 7 takes a little over 2000 cycles
`timescale 1ns/1ps
`default_nettype none

module tb_fw_chain;
  import fw_chain_pkg::*;

  localparam int        WAIT_LIMIT = 5000;     // Cycles per wait loop
  localparam cmd_data_t STATIC_CFG = 24'hC3A587; // Period 7, super_pixel_sel set

  logic      fw_axi_clk;
  logic      op_code_w_reset;
  logic      cmd_valid;
  logic      cmd_ready;
  op_t       cmd_op;
  cmd_data_t cmd_data;
  logic      rsp_valid;
  rd_word_t  rsp_data;
  rd_word_t  status_word;
  logic      super_pixel_sel;
  logic      config_clk;
  logic      reset_not;
  logic      config_in;
  logic      config_load;
  logic      config_out;

  cfg_word_t   model [CFG_WORDS];             // Expected array contents
  logic [31:0] lfsr;
  int          rst_low_cnt;                   // Chip reset cycles seen while active
  int          clk_rise_cnt;                  // config_clk rising edges while active
  int          load_low_cnt;                  // Shift cycles while active

  fw_chain_top uut (
    .fw_axi_clk, .op_code_w_reset,
    .cmd_valid, .cmd_ready, .cmd_op, .cmd_data,
    .rsp_valid, .rsp_data, .status_word,
    .super_pixel_sel, .config_clk, .reset_not,
    .config_in, .config_load, .config_out
  );

  initial begin
    fw_axi_clk = 1'b0;
    forever #10 fw_axi_clk = ~fw_axi_clk;     // 20 ns period
  end

  // ----------------------------------------------------------------------
  // Reporting and compares
  // ----------------------------------------------------------------------
  task automatic abort_run();
    $display("Some tests failed");
    $fatal(1, "Simulation stopped");
  endtask

  task automatic report_timeout(input string what);
    $display("Timeout while waiting for %s", what);
    abort_run();
  endtask

  task automatic check_word(input string what, input rd_word_t got, input rd_word_t exp);
    if (got !== exp) begin
      $display("ERR %0t: %s got %h expected %h", $time, what, got, exp);
      abort_run();
    end
  endtask

  task automatic check_bit(input string what, input logic got, input logic exp);
    if (got !== exp) begin
      $display("ERR %0t: %s got %b expected %b", $time, what, got, exp);
      abort_run();
    end
  endtask

  // Galois LFSR, one step per bit
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 32'h80200003;
    end else begin
      return s >> 1;
    end
  endfunction

  task automatic fill_word(output cfg_word_t w);
    for (int i = 0; i < 16; i++) begin
      lfsr = lfsr_step(lfsr);
      w[i] = lfsr[0];
    end
  endtask

  function automatic cmd_data_t exe_payload(input int delay, input int sample,
                                            input logic loopback, input logic mask);
    cmd_data_t p;
    p = '0;
    p[EXE_DELAY_MSB:EXE_DELAY_LSB]   = delay[6:0];
    p[EXE_SAMPLE_MSB:EXE_SAMPLE_LSB] = sample[6:0];
    p[EXE_LOOPBACK_BIT]              = loopback;
    p[EXE_MASK_RST_BIT]              = mask;
    return p;
  endfunction

  function automatic cmd_data_t addr_payload(input int addr);
    return cmd_data_t'(addr) << ADDR_LSB;
  endfunction

  // ----------------------------------------------------------------------
  // Command port drivers
  // ----------------------------------------------------------------------
  task automatic next_cycle();
    @(posedge fw_axi_clk);
    #2;
  endtask

  // Returns 2 ns after the accepting edge, strobe cycle
  task automatic issue(input op_t op, input cmd_data_t data);
    int n;
    n         = 0;
    cmd_valid = 1'b1;
    cmd_op    = op;
    cmd_data  = data;
    while (!cmd_ready) begin
      next_cycle();
      n++;
      if (n > WAIT_LIMIT) report_timeout("cmd_ready");
    end
    next_cycle();                             // Accepted on this edge
    cmd_valid = 1'b0;
  endtask

  task automatic read_cmd(input op_t op, input cmd_data_t data, output rd_word_t val);
    int n;
    n = 0;
    issue(op, data);
    while (!rsp_valid) begin
      next_cycle();
      n++;
      if (n > WAIT_LIMIT) report_timeout("rsp_valid");
    end
    val = rsp_data;
    check_bit("response two cycles after accept", n == 1, 1'b1);
    next_cycle();
    check_bit("rsp_valid single cycle", rsp_valid, 1'b0);
  endtask

  // Called in the execute strobe cycle, the FSM is active from the next sample
  task automatic wait_done();
    int   n;
    logic clk_prev;
    n            = 0;
    clk_prev     = 1'b0;
    rst_low_cnt  = 0;
    clk_rise_cnt = 0;
    load_low_cnt = 0;
    while (!status_word[STS_DONE]) begin
      if (n > 0) begin
        check_bit("super_pixel_sel while active", super_pixel_sel,
                  STATIC_CFG[STATIC_SPS_BIT]);
        if (!reset_not) begin
          rst_low_cnt++;
          check_bit("config_load during chip reset", config_load, 1'b1);
        end
        if (config_clk && !clk_prev) clk_rise_cnt++;
        if (!config_load) load_low_cnt++;
        clk_prev = config_clk;
      end
      next_cycle();
      n++;
      if (n > WAIT_LIMIT) report_timeout("STS_DONE");
    end
    check_bit("cmd_ready after done", cmd_ready, 1'b1);
  endtask

  task automatic clear_status();
    issue(OP_W_STATUS_CLEAR, '0);
    next_cycle();
    check_word("status after clear", status_word, '0);
  endtask

  task automatic check_data_words(input logic all_ones);
    rd_word_t got;
    rd_word_t exp;
    for (int i = 0; i < DATA_WORDS; i++) begin
      read_cmd(OP_R_DATA, addr_payload(i), got);
      exp = all_ones ? '1 : {model[2*i+1], model[2*i]};
      check_word($sformatf("data word %0d", i), got, exp);
    end
  endtask

  // ----------------------------------------------------------------------
  // Tests
  // ----------------------------------------------------------------------
  task automatic test_reset_state();
    rd_word_t got;
    check_word("status after reset", status_word, rd_word_t'(1) << STS_RESET);
    check_bit("cmd_ready after reset", cmd_ready, 1'b1);
    check_bit("rsp_valid after reset", rsp_valid, 1'b0);
    check_bit("super_pixel_sel after reset", super_pixel_sel, 1'b0);
    check_bit("config_clk after reset", config_clk, 1'b0);
    check_bit("reset_not after reset", reset_not, 1'b0);
    check_bit("config_in after reset", config_in, 1'b0);
    check_bit("config_load after reset", config_load, 1'b0);
    read_cmd(OP_R_STATIC, '0, got);
    check_word("static after reset", got, '0);
    check_word("status after read", status_word,
               (rd_word_t'(1) << STS_RESET) | (rd_word_t'(1) << STS_R_STATIC));
  endtask

  task automatic test_config_rw();
    rd_word_t got;
    issue(OP_W_STATIC, STATIC_CFG);
    read_cmd(OP_R_STATIC, '0, got);
    check_word("static readback", got, 32'h00C3A587);
    for (int a = 0; a < CFG_WORDS; a++) begin
      fill_word(model[a]);
      issue(OP_W_ARRAY, addr_payload(a) | cmd_data_t'(model[a]));
    end
    for (int a = 0; a < CFG_WORDS; a++) begin
      read_cmd(OP_R_ARRAY, addr_payload(a), got);
      check_word($sformatf("array pair %0d", a), got,
                 {model[(a + 1) % CFG_WORDS], model[a]});
    end
  endtask

  task automatic test_loopback();
    rd_word_t got;
    clear_status();
    issue(OP_W_EXECUTE, exe_payload(4, 1, 1'b1, 1'b0));
    wait_done();
    check_bit("no error on loopback", status_word[STS_ERROR], 1'b0);
    check_bit("config_clk rises per shifted bit", clk_rise_cnt >= CHAIN_BITS, 1'b1);
    check_bit("config_load low while shifting", load_low_cnt >= CHAIN_BITS, 1'b1);
    check_data_words(1'b0);
    read_cmd(OP_R_DATA, addr_payload(DATA_WORDS), got);
    check_word("data word out of range", got, '0);
  endtask

  task automatic test_chip_input();
    config_out = 1'b1;
    clear_status();
    issue(OP_W_EXECUTE, exe_payload(4, 1, 1'b0, 1'b0));
    wait_done();
    check_bit("reset pulse seen", rst_low_cnt > 0, 1'b1);
    check_data_words(1'b1);
    clear_status();
    issue(OP_W_EXECUTE, exe_payload(4, 1, 1'b0, 1'b1));   // Now with the reset masked
    wait_done();
    check_bit("reset pulse masked", rst_low_cnt == 0, 1'b1);
    config_out = 1'b0;
  endtask

  task automatic test_bad_delay();
    clear_status();
    issue(OP_W_EXECUTE, exe_payload(1, 0, 1'b1, 1'b0));
    wait_done();
    check_bit("STS_ERROR on delay 1", status_word[STS_ERROR], 1'b1);
    clear_status();
  endtask

  task automatic test_busy_read();
    rd_word_t got;
    clear_status();
    issue(OP_W_EXECUTE, exe_payload(4, 1, 1'b1, 1'b0));
    repeat (3) next_cycle();
    check_bit("cmd_ready while busy", cmd_ready, 1'b0);
    read_cmd(OP_R_DATA, addr_payload(2), got);
    check_bit("done before response", status_word[STS_DONE], 1'b1);
    check_word("data word read while busy", got, {model[5], model[4]});
  endtask

  initial begin
    op_code_w_reset = 1'b1;
    cmd_valid       = 1'b0;
    cmd_op          = OP_W_STATIC;
    cmd_data        = '0;
    config_out      = 1'b0;
    lfsr            = 32'h345141dd;
    for (int i = 0; i < CFG_WORDS; i++) begin
      model[i] = '0;
    end
    repeat (3) @(posedge fw_axi_clk);         // Three reset cycles
    #2;
    op_code_w_reset = 1'b0;

    test_reset_state();
    test_config_rw();
    test_loopback();
    test_chip_input();
    test_bad_delay();
    test_busy_read();

    $display("All tests passed");
    $finish;
  end

endmodule

`default_nettype wire

/* source/status_reg.sv */
// Sticky status word, cleared only by the status clear command
// STS_ERROR follows the setting check of the latest execute
`timescale 1ns/1ps
`default_nettype none

module status_reg (
  input  logic                   fw_axi_clk,
  input  logic                   op_code_w_reset,
  cmd_if.user                    cmd,
  input  logic                   done,
  input  logic                   error,
  output fw_chain_pkg::rd_word_t status_word
);
  import fw_chain_pkg::*;

  rd_word_t sts;
  logic     exe_d;                            // Execute strobe, one cycle late

  always_ff @(posedge fw_axi_clk) begin
    if (op_code_w_reset) begin
      sts   <= rd_word_t'(1) << STS_RESET;
      exe_d <= 1'b0;
    end else begin
      exe_d <= cmd.strobe && (cmd.op == OP_W_EXECUTE);
      if (cmd.strobe && (cmd.op == OP_W_STATUS_CLEAR)) begin
        sts <= '0;
      end else begin
        if (cmd.strobe) begin
          case (cmd.op)
            OP_W_STATIC:  sts[STS_W_STATIC] <= 1'b1;
            OP_R_STATIC:  sts[STS_R_STATIC] <= 1'b1;
            OP_W_ARRAY:   sts[STS_W_ARRAY]  <= 1'b1;
            OP_R_ARRAY:   sts[STS_R_ARRAY]  <= 1'b1;
            OP_R_DATA:    sts[STS_R_DATA]   <= 1'b1;
            OP_W_EXECUTE: sts[STS_EXECUTE]  <= 1'b1;
            default:      ;
          endcase
        end
        if (done) sts[STS_DONE] <= 1'b1;
        if (exe_d) sts[STS_ERROR] <= error;   // Error flag is valid by now
      end
    end
  end

  assign status_word = sts;

endmodule

`default_nettype wire

/* source/chain_test_fsm.sv */
// Chain shift test sequencer and chip pin drive
// Settings outside MIN_DELAY..period flag an error and skip straight to done,
// since the shift point would never be reached
// All chip pins, reset_not included, sit at 0 while idle
`timescale 1ns/1ps
`default_nettype none

module chain_test_fsm (
  input  logic                      fw_axi_clk,
  input  logic                      op_code_w_reset,
  cmd_if.user                       cmd,
  chain_if.seq                      chain,
  input  fw_chain_pkg::clk_period_t clk_counter,
  input  fw_chain_pkg::clk_period_t period,
  input  logic                      config_clk,
  input  logic                      sps_cfg,
  input  logic                      config_out,
  output logic                      super_pixel_sel,
  output logic                      config_clk_pin,
  output logic                      reset_not,
  output logic                      config_in,
  output logic                      config_load,
  output logic                      done,
  output logic                      error
);
  import fw_chain_pkg::*;

  chain_state_t state;
  clk_period_t  delay_q;                      // Shift point in the period
  clk_period_t  sample_q;                     // Capture point in the period
  logic         loopback_q;
  logic         mask_q;                       // Suppress the chip reset pulse
  clk_period_t  exe_delay;
  logic         exe_start;
  logic         exe_err;
  logic         active;
  logic         at_delay;

  assign exe_start = cmd.strobe && (cmd.op == OP_W_EXECUTE) && (state == ST_IDLE);
  assign exe_delay = cmd.payload[EXE_DELAY_MSB:EXE_DELAY_LSB];
  assign exe_err   = (exe_delay < clk_period_t'(MIN_DELAY)) || (exe_delay > period);

  // ----------------------------------------------------------------------
  // Execute settings
  // ----------------------------------------------------------------------
  always_ff @(posedge fw_axi_clk) begin
    if (exe_start) begin
      delay_q    <= exe_delay;
      sample_q   <= cmd.payload[EXE_SAMPLE_MSB:EXE_SAMPLE_LSB];
      loopback_q <= cmd.payload[EXE_LOOPBACK_BIT];
      mask_q     <= cmd.payload[EXE_MASK_RST_BIT];
    end
  end

  always_ff @(posedge fw_axi_clk) begin
    if (op_code_w_reset) begin
      error <= 1'b0;
    end else if (exe_start) begin
      error <= exe_err;                       // Held until the next execute
    end
  end

  // ----------------------------------------------------------------------
  // Sequencer
  // ----------------------------------------------------------------------
  assign at_delay = (clk_counter == delay_q);

  always_ff @(posedge fw_axi_clk) begin
    if (op_code_w_reset) begin
      state <= ST_IDLE;
    end else begin
      case (state)
        ST_IDLE:      if (exe_start) state <= exe_err ? ST_DONE : ST_DELAY;
        ST_DELAY:     if (at_delay) state <= ST_RESET_NOT;  // Load issued here
        ST_RESET_NOT: if (at_delay) state <= ST_SHIFT;      // One full period
        ST_SHIFT:     if (chain.last_bit) state <= ST_DONE;
        ST_DONE:      state <= ST_IDLE;
        default:      state <= ST_IDLE;
      endcase
    end
  end

  // Shifter commands, nothing after the last shift
  assign chain.load    = (state == ST_DELAY) && at_delay;
  assign chain.shift   = (state == ST_SHIFT) && at_delay && !chain.last_bit;
  assign chain.capture = (state == ST_SHIFT) && (clk_counter == sample_q) &&
                         !chain.last_bit;
  assign chain.capture_bit = loopback_q ? config_in : config_out;

  // Chip pins
  assign active          = (state != ST_IDLE);
  assign super_pixel_sel = active && sps_cfg;
  assign config_clk_pin  = active && config_clk;
  assign reset_not       = active && !((state == ST_RESET_NOT) && !mask_q);
  assign config_in       = active && chain.tx_bit;
  assign config_load     = active && (state != ST_SHIFT);   // Low only while shifting

  assign done     = (state == ST_DONE);       // Single cycle
  assign cmd.busy = active;

endmodule

`default_nettype wire

/* source/chain_shifter.sv */
// Outgoing chain register, shift counter and capture register
// Bits leave from bit 0 and enter at the top, so a clean loopback returns the image
// Readback words at DATA_WORDS and above read as zero
`timescale 1ns/1ps
`default_nettype none

module chain_shifter (
  input  logic                     fw_axi_clk,
  input  logic                     op_code_w_reset,
  chain_if.data                    chain,
  input  fw_chain_pkg::chain_vec_t chain_image,
  cmd_if.user                      cmd,
  output fw_chain_pkg::rd_word_t   data_word
);
  import fw_chain_pkg::*;

  localparam int WSEL_W = $clog2(DATA_WORDS);

  chain_vec_t        tx_sr;                   // Outgoing bits
  chain_vec_t        rx_sr;                   // Captured bits
  bit_cnt_t          bit_cnt;
  cfg_addr_t         addr;
  logic [WSEL_W-1:0] wsel;

  // ----------------------------------------------------------------------
  // Shift side
  // ----------------------------------------------------------------------
  always_ff @(posedge fw_axi_clk) begin
    if (op_code_w_reset) begin
      bit_cnt <= '0;
    end else if (chain.load) begin
      bit_cnt <= '0;
    end else if (chain.shift) begin
      bit_cnt <= bit_cnt + 1'b1;
    end
  end

  always_ff @(posedge fw_axi_clk) begin
    if (chain.load) begin
      tx_sr <= chain_image;
    end else if (chain.shift) begin
      tx_sr <= {1'b0, tx_sr[CHAIN_BITS-1:1]};  // Right shift, zero fill
    end
  end

  assign chain.tx_bit   = tx_sr[0];
  assign chain.last_bit = (bit_cnt == bit_cnt_t'(CHAIN_BITS));

  // Capture side
  always_ff @(posedge fw_axi_clk) begin
    if (chain.capture) begin
      rx_sr <= {chain.capture_bit, rx_sr[CHAIN_BITS-1:1]};
    end
  end

  // ----------------------------------------------------------------------
  // Readback word select
  // ----------------------------------------------------------------------
  assign addr = cmd.payload[ADDR_MSB:ADDR_LSB];
  assign wsel = addr[WSEL_W-1:0];

  always_comb begin
    if (addr < cfg_addr_t'(DATA_WORDS)) begin
      data_word = rx_sr[wsel*32 +: 32];
    end else begin
      data_word = '0;                         // Out of range
    end
  end

endmodule

`default_nettype wire

/* source/config_clk_gen.sv */
// Configuration clock from a free running period counter
// One config_clk cycle spans period + 1 fast clock cycles
`timescale 1ns/1ps
`default_nettype none

module config_clk_gen #(
  parameter int CNT_WIDTH = 7
) (
  input  logic                 fw_axi_clk,
  input  logic                 op_code_w_reset,
  input  logic [CNT_WIDTH-1:0] period,
  output logic [CNT_WIDTH-1:0] clk_counter,
  output logic                 config_clk
);

  always_ff @(posedge fw_axi_clk) begin
    if (op_code_w_reset) begin
      clk_counter <= '0;
    end else if (clk_counter >= period) begin
      clk_counter <= '0;                      // Wrap, also catches a period lowered mid count
    end else begin
      clk_counter <= clk_counter + 1'b1;
    end
  end

  // High in the upper half of the count
  assign config_clk = (clk_counter > (period >> 1));

endmodule

`default_nettype wire

/* source/config_regs.sv */
// Static configuration word and the configuration array behind the chain
// Array addresses wrap modulo CFG_WORDS, the paired read included
`timescale 1ns/1ps
`default_nettype none

module config_regs (
  input  logic                    fw_axi_clk,
  input  logic                    op_code_w_reset,
  cmd_if.user                     cmd,
  output fw_chain_pkg::cmd_data_t static_word,
  output fw_chain_pkg::chain_vec_t chain_image,
  output fw_chain_pkg::rd_word_t  arr_pair
);
  import fw_chain_pkg::*;

  localparam int AW = $clog2(CFG_WORDS);

  cfg_word_t       cfg_mem [CFG_WORDS];
  cfg_addr_t       addr;
  logic [AW-1:0]   idx;
  logic [AW-1:0]   idx_nxt;

  assign addr    = cmd.payload[ADDR_MSB:ADDR_LSB];
  assign idx     = addr[AW-1:0];              // Upper address bits ignored
  assign idx_nxt = idx + 1'b1;                // Wraps at CFG_WORDS

  // ----------------------------------------------------------------------
  // Writes
  // ----------------------------------------------------------------------
  always_ff @(posedge fw_axi_clk) begin
    if (op_code_w_reset) begin
      static_word <= '0;
      for (int i = 0; i < CFG_WORDS; i++) begin
        cfg_mem[i] <= '0;
      end
    end else if (cmd.strobe) begin
      if (cmd.op == OP_W_STATIC) begin
        static_word <= cmd.payload;
      end
      if (cmd.op == OP_W_ARRAY) begin
        cfg_mem[idx] <= cmd.payload[15:0];
      end
    end
  end

  // Paired read, next entry in the upper half
  assign arr_pair = {cfg_mem[idx_nxt], cfg_mem[idx]};

  // Flat chain image, entry 0 shifts out first
  always_comb begin
    for (int i = 0; i < CFG_WORDS; i++) begin
      chain_image[i*16 +: 16] = cfg_mem[i];
    end
  end

endmodule

`default_nettype wire

/* source/cmd_decoder.sv */
// Command port front end: one command in flight per cycle, no response back-pressure
// Reads answer exactly two cycles after acceptance
// cmd_ready drops as soon as an execute is strobed and stays low while the test runs
`timescale 1ns/1ps
`default_nettype none

module cmd_decoder (
  input  logic                   fw_axi_clk,
  input  logic                   op_code_w_reset,
  input  logic                   cmd_valid,
  output logic                   cmd_ready,
  input  fw_chain_pkg::op_t      cmd_op,
  input  fw_chain_pkg::cmd_data_t cmd_data,
  input  fw_chain_pkg::rd_word_t arr_pair,
  input  fw_chain_pkg::rd_word_t data_word,
  input  fw_chain_pkg::cmd_data_t static_word,
  output logic                   rsp_valid,
  output fw_chain_pkg::rd_word_t rsp_data,
  cmd_if.dec                     cmd
);
  import fw_chain_pkg::*;

  logic accept;
  logic is_read;

  // Block the cycle of an execute strobe too, the FSM only goes busy one cycle later
  assign cmd_ready = !(cmd.busy || (cmd.strobe && (cmd.op == OP_W_EXECUTE)));
  assign accept    = cmd_valid && cmd_ready;
  assign is_read   = (cmd.op == OP_R_STATIC) || (cmd.op == OP_R_ARRAY) ||
                     (cmd.op == OP_R_DATA);

  // ----------------------------------------------------------------------
  // Command strobe
  // ----------------------------------------------------------------------
  always_ff @(posedge fw_axi_clk) begin
    if (op_code_w_reset) begin
      cmd.strobe <= 1'b0;
    end else begin
      cmd.strobe <= accept;                   // One cycle per accepted command
    end
  end

  always_ff @(posedge fw_axi_clk) begin
    if (accept) begin
      cmd.op      <= cmd_op;
      cmd.payload <= cmd_data;
    end
  end

  // Response register
  always_ff @(posedge fw_axi_clk) begin
    if (op_code_w_reset) begin
      rsp_valid <= 1'b0;
    end else begin
      rsp_valid <= cmd.strobe && is_read;
    end
  end

  always_ff @(posedge fw_axi_clk) begin
    if (cmd.strobe) begin
      case (cmd.op)
        OP_R_STATIC: rsp_data <= rd_word_t'(static_word);   // Zero padded
        OP_R_ARRAY:  rsp_data <= arr_pair;
        OP_R_DATA:   rsp_data <= data_word;
        default:     ;
      endcase
    end
  end

endmodule

`default_nettype wire

/* source/fw_chain_top.sv */
// Chain test block top level with the internal command and chain buses
// The command port takes one command at a time; responses cannot be stalled
// config_out is the only chip input and is sampled on the fast clock
`timescale 1ns/1ps
`default_nettype none

// ----------------------------------------------------------------------
// Command strobe bus, decoder to consumers
// ----------------------------------------------------------------------
interface cmd_if;
  import fw_chain_pkg::*;

  logic      strobe;                          // One cycle per command
  op_t       op;
  cmd_data_t payload;
  logic      busy;                            // Test running

  modport dec  (output strobe, op, payload, input busy);
  modport user (input strobe, op, payload, output busy);
endinterface

// Sequencer to shifter
interface chain_if;
  logic load;
  logic shift;
  logic capture;
  logic capture_bit;
  logic tx_bit;                               // Bit on config_in
  logic last_bit;

  modport seq  (output load, shift, capture, capture_bit, input tx_bit, last_bit);
  modport data (input load, shift, capture, capture_bit, output tx_bit, last_bit);
endinterface

module fw_chain_top (
  input  logic                    fw_axi_clk,
  input  logic                    op_code_w_reset,
  input  logic                    cmd_valid,
  output logic                    cmd_ready,
  input  fw_chain_pkg::op_t       cmd_op,
  input  fw_chain_pkg::cmd_data_t cmd_data,
  output logic                    rsp_valid,
  output fw_chain_pkg::rd_word_t  rsp_data,
  output fw_chain_pkg::rd_word_t  status_word,
  output logic                    super_pixel_sel,
  output logic                    config_clk,
  output logic                    reset_not,
  output logic                    config_in,
  output logic                    config_load,
  input  logic                    config_out
);
  import fw_chain_pkg::*;

  cmd_data_t   static_word;
  chain_vec_t  chain_image;
  rd_word_t    arr_pair;
  rd_word_t    data_word;
  clk_period_t clk_counter;
  logic        cfg_clk_raw;                   // Free running, gated at the pin
  logic        done;
  logic        error;

  cmd_if   cmd_bus ();
  chain_if chain_bus ();

  cmd_decoder u_dec (
    .fw_axi_clk, .op_code_w_reset,
    .cmd_valid, .cmd_ready, .cmd_op, .cmd_data,
    .arr_pair, .data_word, .static_word,
    .rsp_valid, .rsp_data,
    .cmd (cmd_bus.dec)
  );

  config_regs u_regs (
    .fw_axi_clk, .op_code_w_reset,
    .cmd (cmd_bus.user),
    .static_word, .chain_image, .arr_pair
  );

  config_clk_gen #(.CNT_WIDTH($bits(clk_period_t))) u_clk (
    .fw_axi_clk, .op_code_w_reset,
    .period      (static_word[STATIC_PERIOD_MSB:STATIC_PERIOD_LSB]),
    .clk_counter (clk_counter),
    .config_clk  (cfg_clk_raw)
  );

  chain_shifter u_shift (
    .fw_axi_clk, .op_code_w_reset,
    .chain (chain_bus.data),
    .chain_image,
    .cmd   (cmd_bus.user),
    .data_word
  );

  chain_test_fsm u_fsm (
    .fw_axi_clk, .op_code_w_reset,
    .cmd            (cmd_bus.user),
    .chain          (chain_bus.seq),
    .clk_counter,
    .period         (static_word[STATIC_PERIOD_MSB:STATIC_PERIOD_LSB]),
    .config_clk     (cfg_clk_raw),
    .sps_cfg        (static_word[STATIC_SPS_BIT]),
    .config_out,
    .super_pixel_sel,
    .config_clk_pin (config_clk),
    .reset_not, .config_in, .config_load,
    .done, .error
  );

  status_reg u_sts (
    .fw_axi_clk, .op_code_w_reset,
    .cmd (cmd_bus.user),
    .done, .error, .status_word
  );

endmodule

`default_nettype wire

/* source/fw_chain_pkg.sv */
// Shared widths, field positions and encodings for the chain test block
// The chain is CFG_WORDS entries of 16 bits; CHAIN_BITS must equal CFG_WORDS * 16
// Payload fields assume the 24-bit command word of the software port
`default_nettype none

package fw_chain_pkg;

  // ----------------------------------------------------------------------
  // Sizes
  // ----------------------------------------------------------------------
  localparam int CFG_WORDS  = 16;             // Configuration array depth
  localparam int CHAIN_BITS = 256;            // Serial chain length
  localparam int DATA_WORDS = 8;              // 32-bit readback words

  localparam int ADDR_LSB = 16;               // Address field in the payload
  localparam int ADDR_MSB = 23;

  // Static word fields
  localparam int STATIC_PERIOD_LSB = 0;
  localparam int STATIC_PERIOD_MSB = 6;
  localparam int STATIC_SPS_BIT    = 7;       // super_pixel_sel

  // Execute payload fields
  localparam int EXE_DELAY_LSB    = 0;
  localparam int EXE_DELAY_MSB    = 6;
  localparam int EXE_SAMPLE_LSB   = 7;
  localparam int EXE_SAMPLE_MSB   = 13;
  localparam int EXE_LOOPBACK_BIT = 18;
  localparam int EXE_MASK_RST_BIT = 23;

  localparam int MIN_DELAY = 3;               // Smallest usable shift point

  // Status bit positions
  localparam int STS_RESET    = 0;
  localparam int STS_W_STATIC = 1;
  localparam int STS_R_STATIC = 2;
  localparam int STS_W_ARRAY  = 3;
  localparam int STS_R_ARRAY  = 4;
  localparam int STS_R_DATA   = 5;
  localparam int STS_EXECUTE  = 6;
  localparam int STS_DONE     = 12;
  localparam int STS_ERROR    = 31;

  typedef logic [23:0]           cmd_data_t;
  typedef logic [31:0]           rd_word_t;
  typedef logic [15:0]           cfg_word_t;
  typedef logic [7:0]            cfg_addr_t;
  typedef logic [6:0]            clk_period_t;
  typedef logic [CHAIN_BITS-1:0] chain_vec_t;
  typedef logic [8:0]            bit_cnt_t;   // Counts up to CHAIN_BITS inclusive

  typedef enum logic [2:0] {
    OP_W_STATIC       = 3'd0,
    OP_R_STATIC       = 3'd1,
    OP_W_ARRAY        = 3'd2,
    OP_R_ARRAY        = 3'd3,
    OP_R_DATA         = 3'd4,
    OP_W_STATUS_CLEAR = 3'd5,
    OP_W_EXECUTE      = 3'd6
  } op_t;

  typedef enum logic [2:0] {
    ST_IDLE      = 3'd0,
    ST_DELAY     = 3'd1,
    ST_RESET_NOT = 3'd2,
    ST_SHIFT     = 3'd3,
    ST_DONE      = 3'd4
  } chain_state_t;

endpackage

`default_nettype wire
